// ==== core_pkg.sv ====
// Core package with privilege levels, exception cause codes and data word width

`default_nettype none

package core_pkg;

    ////////////////////
    // Word widths
    ////////////////////

    // Width of a CSR data word
    localparam int XLEN = 32;

    ////////////////////
    // Privilege
    ////////////////////

    // RISC-V privilege encoding, 2'b10 is reserved
    typedef enum logic [1:0] {
        PRIV_USER       = 2'b00,
        PRIV_SUPERVISOR = 2'b01,
        PRIV_MACHINE    = 2'b11
    } privilege_e;

    ////////////////////
    // Exception causes
    ////////////////////

    // Subset of mcause codes raised by the protected-memory path
    // Zero marks an idle report slot
    typedef enum logic [4:0] {
        EXC_NONE               = 5'd0,
        EXC_INST_ACCESS_FAULT  = 5'd1,
        EXC_LOAD_ACCESS_FAULT  = 5'd5,
        EXC_STORE_ACCESS_FAULT = 5'd7
    } exc_code_e;

endpackage

`default_nettype wire

// ==== mvm_pkg.sv ====
// Window CSR package with address map and register reset values

`default_nettype none

package mvm_pkg;

    // Width of a CSR address
    localparam int CSR_ADDR_WIDTH = 12;

    ////////////////////
    // CSR address map
    ////////////////////

    // Control, bit 0 turns translation on
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MVMCTL = 12'h7C0;
    // Data window offset, size, mask
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MVMDO  = 12'h7C1;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MVMDS  = 12'h7C2;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MVMDM  = 12'h7C3;
    // Instruction window offset, size, mask
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MVMIO  = 12'h7C4;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MVMIS  = 12'h7C5;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_MVMIM  = 12'h7C6;

    ////////////////////
    // Reset values
    ////////////////////

    // Full word wide, a window register keeps the low bits it needs
    // Out of reset a window is the identity over the whole space
    localparam logic [core_pkg::XLEN-1:0] MVM_OFFSET_RST = '0;
    localparam logic [core_pkg::XLEN-1:0] MVM_SIZE_RST   = '1;
    localparam logic [core_pkg::XLEN-1:0] MVM_MASK_RST   = '1;

endpackage

`default_nettype wire

// ==== mvm_csr_bank.sv ====
// Window CSR bank module with seven registers, read-back mux and translation enable

`default_nettype none
`timescale 1ns/1ps

module mvm_csr_bank #(
    parameter int AddrWidth = 32
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  core_pkg::privilege_e                privilege_i,
    input  logic                                csr_we_i,
    input  logic [mvm_pkg::CSR_ADDR_WIDTH-1:0]  csr_addr_i,
    input  logic [core_pkg::XLEN-1:0]           csr_wdata_i,
    output logic [core_pkg::XLEN-1:0]           csr_rdata_o,
    output logic                                translation_en_o,
    output logic [AddrWidth-1:0]                d_offset_o,
    output logic [AddrWidth-1:0]                d_size_o,
    output logic [AddrWidth-1:0]                d_mask_o,
    output logic [AddrWidth-1:0]                i_offset_o,
    output logic [AddrWidth-1:0]                i_size_o,
    output logic [AddrWidth-1:0]                i_mask_o
);

    // Stored control bit
    logic mvmctl_q;
    // Address hits one of the seven registers
    logic addr_valid;

    ////////////////////
    // Register writes
    ////////////////////

    // Window registers keep the low AddrWidth bits of the write data
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mvmctl_q   <= 1'b0;
            d_offset_o <= mvm_pkg::MVM_OFFSET_RST[AddrWidth-1:0];
            d_size_o   <= mvm_pkg::MVM_SIZE_RST[AddrWidth-1:0];
            d_mask_o   <= mvm_pkg::MVM_MASK_RST[AddrWidth-1:0];
            i_offset_o <= mvm_pkg::MVM_OFFSET_RST[AddrWidth-1:0];
            i_size_o   <= mvm_pkg::MVM_SIZE_RST[AddrWidth-1:0];
            i_mask_o   <= mvm_pkg::MVM_MASK_RST[AddrWidth-1:0];
        end
        else if (csr_we_i) begin
            case (csr_addr_i)
                // Only the enable bit exists in mvmctl
                mvm_pkg::CSR_MVMCTL: mvmctl_q   <= csr_wdata_i[0];
                mvm_pkg::CSR_MVMDO:  d_offset_o <= csr_wdata_i[AddrWidth-1:0];
                mvm_pkg::CSR_MVMDS:  d_size_o   <= csr_wdata_i[AddrWidth-1:0];
                mvm_pkg::CSR_MVMDM:  d_mask_o   <= csr_wdata_i[AddrWidth-1:0];
                mvm_pkg::CSR_MVMIO:  i_offset_o <= csr_wdata_i[AddrWidth-1:0];
                mvm_pkg::CSR_MVMIS:  i_size_o   <= csr_wdata_i[AddrWidth-1:0];
                mvm_pkg::CSR_MVMIM:  i_mask_o   <= csr_wdata_i[AddrWidth-1:0];
                // Foreign CSR, not ours
                default: ;
            endcase
        end
    end

    ////////////////////
    // Read-back mux
    ////////////////////

    // Zero-extended to the CSR word, unknown addresses read zero
    always_comb begin
        csr_rdata_o = '0;
        addr_valid  = 1'b1;
        case (csr_addr_i)
            mvm_pkg::CSR_MVMCTL: csr_rdata_o[0]           = mvmctl_q;
            mvm_pkg::CSR_MVMDO:  csr_rdata_o[AddrWidth-1:0] = d_offset_o;
            mvm_pkg::CSR_MVMDS:  csr_rdata_o[AddrWidth-1:0] = d_size_o;
            mvm_pkg::CSR_MVMDM:  csr_rdata_o[AddrWidth-1:0] = d_mask_o;
            mvm_pkg::CSR_MVMIO:  csr_rdata_o[AddrWidth-1:0] = i_offset_o;
            mvm_pkg::CSR_MVMIS:  csr_rdata_o[AddrWidth-1:0] = i_size_o;
            mvm_pkg::CSR_MVMIM:  csr_rdata_o[AddrWidth-1:0] = i_mask_o;
            default:             addr_valid               = 1'b0;
        endcase
    end

    // Machine mode always sees physical addresses
    assign translation_en_o = (privilege_i != core_pkg::PRIV_MACHINE) && mvmctl_q;

    // Write strobe only ever targets a window register
    assert property (@(posedge clk) disable iff (!arst_n_i) csr_we_i |-> addr_valid)
        else $error("CSR write to unknown address %h", csr_addr_i);

endmodule

`default_nettype wire

// ==== mmu_window.sv ====
// Address window module with masking, relocation and bounds fault

`default_nettype none
`timescale 1ns/1ps

module mmu_window #(
    parameter int AddrWidth = 32
) (
    input  logic                 en_i,
    input  logic [AddrWidth-1:0] mask_i,
    input  logic [AddrWidth-1:0] offset_i,
    input  logic [AddrWidth-1:0] size_i,
    input  logic [AddrWidth-1:0] address_i,
    output logic [AddrWidth-1:0] address_o,
    output logic                 fault_o
);

    // Virtual address with the window mask applied
    logic [AddrWidth-1:0] masked_addr;
    // Relocated physical address wrapping at AddrWidth
    logic [AddrWidth-1:0] relocated_addr;
    // Virtual address beyond the window size
    logic                 out_of_bounds;

    ////////////////////
    // Translation
    ////////////////////

    assign masked_addr    = address_i & mask_i;
    assign relocated_addr = offset_i + masked_addr;

    // Bounds check on the raw address rather than the masked one
    assign out_of_bounds  = (address_i >= size_i);

    // Pass through untouched while disabled
    always_comb begin
        if (en_i) begin
            address_o = relocated_addr;
            fault_o   = out_of_bounds;
        end
        else begin
            address_o = address_i;
            fault_o   = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== access_guard.sv ====
// Memory guard module with request gating and registered exception report

`default_nettype none
`timescale 1ns/1ps

module access_guard (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                inst_fault_i,
    input  logic                data_fault_i,
    input  logic                killed_i,
    input  logic                mem_read_enable_i,
    input  logic [3:0]          mem_write_enable_i,
    output logic                mem_operation_enable_o,
    output logic [3:0]          mem_write_enable_o,
    output logic                exc_valid_o,
    output core_pkg::exc_code_e exc_code_o
);

    // Request that actually reaches memory unless faulted
    logic                live_req;
    // Any byte lane written
    logic                store_req;
    // Next report
    logic                exc_valid_d;
    core_pkg::exc_code_e exc_code_d;

    ////////////////////
    // Request gating
    ////////////////////

    assign store_req = |mem_write_enable_i;
    assign live_req  = !killed_i && (mem_read_enable_i || store_req);

    // Data fault blocks the access in the same cycle
    assign mem_operation_enable_o = live_req && !data_fault_i;
    assign mem_write_enable_o     = mem_write_enable_i;

    ////////////////////
    // Fault ranking
    ////////////////////

    // Fetch fault wins over data fault
    // Data fault only counts on a live request
    always_comb begin
        exc_valid_d = 1'b0;
        exc_code_d  = core_pkg::EXC_NONE;
        if (inst_fault_i) begin
            exc_valid_d = 1'b1;
            exc_code_d  = core_pkg::EXC_INST_ACCESS_FAULT;
        end
        else if (data_fault_i && live_req) begin
            exc_valid_d = 1'b1;
            // Store if any strobe set and load otherwise
            exc_code_d  = store_req ? core_pkg::EXC_STORE_ACCESS_FAULT
                                    : core_pkg::EXC_LOAD_ACCESS_FAULT;
        end
    end

    // One report per cycle and one cycle late
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            exc_valid_o <= 1'b0;
            exc_code_o  <= core_pkg::EXC_NONE;
        end
        else begin
            exc_valid_o <= exc_valid_d;
            exc_code_o  <= exc_code_d;
        end
    end

endmodule

`default_nettype wire

// ==== xosvm_unit.sv ====
// Protected-memory top module with CSR bank, instruction and data windows and guard

`default_nettype none
`timescale 1ns/1ps

module xosvm_unit #(
    parameter int AddrWidth = 32
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  core_pkg::privilege_e                privilege_i,
    // CSR port
    input  logic                                csr_we_i,
    input  logic [mvm_pkg::CSR_ADDR_WIDTH-1:0]  csr_addr_i,
    input  logic [core_pkg::XLEN-1:0]           csr_wdata_i,
    output logic [core_pkg::XLEN-1:0]           csr_rdata_o,
    // Virtual side
    input  logic [AddrWidth-1:0]                instruction_address_i,
    input  logic [AddrWidth-1:0]                mem_address_i,
    input  logic                                mem_read_enable_i,
    input  logic [3:0]                          mem_write_enable_i,
    input  logic                                killed_i,
    // Physical side
    output logic [AddrWidth-1:0]                instruction_address_o,
    output logic                                inst_fault_o,
    output logic [AddrWidth-1:0]                mem_address_o,
    output logic                                mem_operation_enable_o,
    output logic [3:0]                          mem_write_enable_o,
    // Exception report
    output logic                                exc_valid_o,
    output core_pkg::exc_code_e                 exc_code_o
);

    logic                 translation_en;
    logic                 data_fault;
    // Window registers
    logic [AddrWidth-1:0] d_offset, d_size, d_mask;
    logic [AddrWidth-1:0] i_offset, i_size, i_mask;

    ////////////////////
    // CSR bank
    ////////////////////

    mvm_csr_bank #(
        .AddrWidth (AddrWidth)
    ) csr_bank_i (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .privilege_i      (privilege_i),
        .csr_we_i         (csr_we_i),
        .csr_addr_i       (csr_addr_i),
        .csr_wdata_i      (csr_wdata_i),
        .csr_rdata_o      (csr_rdata_o),
        .translation_en_o (translation_en),
        .d_offset_o       (d_offset),
        .d_size_o         (d_size),
        .d_mask_o         (d_mask),
        .i_offset_o       (i_offset),
        .i_size_o         (i_size),
        .i_mask_o         (i_mask)
    );

    ////////////////////
    // Windows
    ////////////////////

    // Fetch side
    mmu_window #(.AddrWidth(AddrWidth)) i_window (
        .en_i      (translation_en),
        .mask_i    (i_mask),
        .offset_i  (i_offset),
        .size_i    (i_size),
        .address_i (instruction_address_i),
        .address_o (instruction_address_o),
        .fault_o   (inst_fault_o)
    );

    // Load/store side
    mmu_window #(.AddrWidth(AddrWidth)) d_window (
        .en_i      (translation_en),
        .mask_i    (d_mask),
        .offset_i  (d_offset),
        .size_i    (d_size),
        .address_i (mem_address_i),
        .address_o (mem_address_o),
        .fault_o   (data_fault)
    );

    // Merge both faults into gating and one report
    access_guard guard_i (
        .clk                    (clk),
        .arst_n_i               (arst_n_i),
        .inst_fault_i           (inst_fault_o),
        .data_fault_i           (data_fault),
        .killed_i               (killed_i),
        .mem_read_enable_i      (mem_read_enable_i),
        .mem_write_enable_i     (mem_write_enable_i),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .exc_valid_o            (exc_valid_o),
        .exc_code_o             (exc_code_o)
    );

endmodule

`default_nettype wire

// ==== tb_model.svh ====
// Testbench model with shadow window CSRs, window rule, request gating, cause ranking and xorshift
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Base of the seven window CSRs
localparam logic [11:0] A_CTL = 12'h7C0;

// Shadow CSRs indexed by address minus 0x7C0
// 0 ctl, 1..3 data offset/size/mask, 4..6 instruction offset/size/mask
logic [ADDR_W-1:0] shadow [7];

////////////////////
// Random numbers
////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

////////////////////
// CSR shadow
////////////////////

// Offsets and control cleared while sizes and masks go all ones
task automatic shadow_reset();
    for (int i = 0; i < 7; i++) begin
        if (i == 0 || i == 1 || i == 4)
            shadow[i] = {ADDR_W{1'b0}};
        else
            shadow[i] = {ADDR_W{1'b1}};
    end
endtask

task automatic shadow_write(input logic [11:0] addr, input logic [31:0] data);
    int idx;
    idx = int'(addr) - 32'h7C0;
    // Control keeps bit 0 only
    if (idx == 0)
        shadow[0] = {{(ADDR_W-1){1'b0}}, data[0]};
    else if (idx > 0 && idx < 7)
        shadow[idx] = data[ADDR_W-1:0];
endtask

// Zero-extended read with foreign addresses reading zero
function automatic logic [31:0] expected_rdata(input logic [11:0] addr);
    int idx;
    idx = int'(addr) - 32'h7C0;
    if (idx >= 0 && idx < 7)
        return 32'(shadow[idx]);
    return 32'h0;
endfunction

////////////////////
// Windows and guard
////////////////////

// Machine mode (2'b11) never translates
function automatic logic translation_on(input logic [1:0] priv);
    return (priv != 2'b11) && shadow[0][0];
endfunction

function automatic logic [ADDR_W-1:0] window_addr(input logic en,
                                                  input logic [ADDR_W-1:0] mask,
                                                  input logic [ADDR_W-1:0] offset,
                                                  input logic [ADDR_W-1:0] addr);
    if (en)
        return offset + (addr & mask);
    return addr;
endfunction

// Bounds on the raw address
function automatic logic window_fault(input logic en, input logic [ADDR_W-1:0] size,
                                      input logic [ADDR_W-1:0] addr);
    return en && (addr >= size);
endfunction

function automatic logic request_allowed(input logic killed, input logic rd,
                                         input logic [3:0] wstrb, input logic dfault);
    return !killed && (rd || (wstrb != 4'h0)) && !dfault;
endfunction

// Returns {valid, code} with the fetch fault ranked above a data fault on a live request
function automatic logic [5:0] expected_cause(input logic ifault, input logic dfault,
                                              input logic killed, input logic rd,
                                              input logic [3:0] wstrb);
    if (ifault)
        return {1'b1, 5'd1};
    if (dfault && !killed && (rd || (wstrb != 4'h0)))
        return {1'b1, (wstrb != 4'h0) ? 5'd7 : 5'd5};
    return 6'd0;
endfunction

`endif

// ==== tb_xosvm_unit.sv ====
// Testbench top with clock, reset, random traffic and checks against the model

`default_nettype none
`timescale 1ns/1ps

module tb_xosvm_unit;

    localparam int ADDR_W        = 32;
    localparam int RESET_TIMEOUT = 20;

    logic                 clk;
    logic                 arst_n_i;
    core_pkg::privilege_e privilege_i;
    logic                 csr_we_i;
    logic [11:0]          csr_addr_i;
    logic [31:0]          csr_wdata_i;
    logic [31:0]          csr_rdata_o;
    logic [ADDR_W-1:0]    instruction_address_i;
    logic [ADDR_W-1:0]    mem_address_i;
    logic                 mem_read_enable_i;
    logic [3:0]           mem_write_enable_i;
    logic                 killed_i;
    logic [ADDR_W-1:0]    instruction_address_o;
    logic                 inst_fault_o;
    logic [ADDR_W-1:0]    mem_address_o;
    logic                 mem_operation_enable_o;
    logic [3:0]           mem_write_enable_o;
    logic                 exc_valid_o;
    core_pkg::exc_code_e  exc_code_o;

    // Generator state
    logic [31:0] rnd;
    // Report due after the next rising edge
    logic [5:0]  exp_exc;
    logic        reset_ok;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    string       test_name;

    `include "tb_model.svh"

    xosvm_unit #(.AddrWidth(ADDR_W)) xosvm_unit_i (.*);

    always #20 clk = ~clk;

    // Five cycles of reset, released on a falling edge
    initial begin
        arst_n_i = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic next_rand();
        rnd = xorshift32(rnd);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error: %s is %h, expected %h (test %s)", name, got, exp, test_name);
        errors++;
        test_errors++;
    endtask

    task automatic wait_reset(output logic ok);
        int cycles;
        cycles = 0;
        while (arst_n_i !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (arst_n_i === 1'b1);
    endtask

    // Falling edge, registered report from the previous cycle
    task automatic next_edge();
        @(negedge clk);
        if (exc_valid_o !== exp_exc[5])
            report_mismatch("exc_valid_o", 32'(exc_valid_o), 32'(exp_exc[5]));
        if (exc_code_o !== exp_exc[4:0])
            report_mismatch("exc_code_o", 32'(exc_code_o), 32'(exp_exc[4:0]));
    endtask

    // Combinational outputs, a quarter period after the drive
    task automatic check_outputs();
        logic              ten;
        logic              ifault;
        logic              dfault;
        logic [ADDR_W-1:0] exp_iaddr;
        logic [ADDR_W-1:0] exp_maddr;
        logic [31:0]       exp_rdata;
        logic              exp_op;
        #10;
        ten       = translation_on(privilege_i);
        ifault    = window_fault(ten, shadow[5], instruction_address_i);
        dfault    = window_fault(ten, shadow[2], mem_address_i);
        exp_iaddr = window_addr(ten, shadow[6], shadow[4], instruction_address_i);
        exp_maddr = window_addr(ten, shadow[3], shadow[1], mem_address_i);
        exp_rdata = expected_rdata(csr_addr_i);
        exp_op    = request_allowed(killed_i, mem_read_enable_i, mem_write_enable_i, dfault);
        if (csr_rdata_o !== exp_rdata)
            report_mismatch("csr_rdata_o", csr_rdata_o, exp_rdata);
        if (instruction_address_o !== exp_iaddr)
            report_mismatch("instruction_address_o", 32'(instruction_address_o), 32'(exp_iaddr));
        if (inst_fault_o !== ifault)
            report_mismatch("inst_fault_o", 32'(inst_fault_o), 32'(ifault));
        if (mem_address_o !== exp_maddr)
            report_mismatch("mem_address_o", 32'(mem_address_o), 32'(exp_maddr));
        if (mem_operation_enable_o !== exp_op)
            report_mismatch("mem_operation_enable_o", 32'(mem_operation_enable_o), 32'(exp_op));
        if (mem_write_enable_o !== mem_write_enable_i)
            report_mismatch("mem_write_enable_o", 32'(mem_write_enable_o),
                            32'(mem_write_enable_i));
        // Report one edge later, CSR write takes effect one cycle later
        exp_exc = expected_cause(ifault, dfault, killed_i, mem_read_enable_i, mem_write_enable_i);
        if (csr_we_i)
            shadow_write(csr_addr_i, csr_wdata_i);
    endtask

    ////////////////////
    // Cycle drivers
    ////////////////////

    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        next_edge();
        csr_we_i    = 1'b1;
        csr_addr_i  = addr;
        csr_wdata_i = data;
        check_outputs();
    endtask

    task automatic csr_read(input logic [11:0] addr);
        next_edge();
        csr_we_i   = 1'b0;
        csr_addr_i = addr;
        check_outputs();
    endtask

    task automatic set_priv(input core_pkg::privilege_e priv);
        next_edge();
        csr_we_i    = 1'b0;
        privilege_i = priv;
        check_outputs();
    endtask

    // Random offset, size and mask for both windows
    task automatic random_window();
        for (int i = 1; i < 7; i++) begin
            next_rand();
            csr_write(A_CTL + 12'(i), rnd);
        end
    endtask

    // Random fetch and data traffic, CSR port idle
    task automatic traffic_cycle(input logic rand_priv);
        next_edge();
        csr_we_i = 1'b0;
        if (rand_priv) begin
            next_rand();
            case (rnd[1:0])
                2'd0:    privilege_i = core_pkg::PRIV_USER;
                2'd1:    privilege_i = core_pkg::PRIV_SUPERVISOR;
                default: privilege_i = core_pkg::PRIV_MACHINE;
            endcase
        end
        next_rand();
        instruction_address_i = rnd[ADDR_W-1:0];
        next_rand();
        mem_address_i = rnd[ADDR_W-1:0];
        next_rand();
        // Few killed, about half stores
        killed_i           = (rnd[2:0] == 3'd0);
        mem_read_enable_i  = rnd[3];
        mem_write_enable_i = rnd[4] ? rnd[8:5] : 4'h0;
        check_outputs();
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: ok", test_name);
        end
        else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        logic [11:0] rt_addr;
        clk                   = 1'b0;
        privilege_i           = core_pkg::PRIV_MACHINE;
        csr_we_i              = 1'b0;
        csr_addr_i            = A_CTL;
        csr_wdata_i           = 32'h0;
        instruction_address_i = '0;
        mem_address_i         = '0;
        mem_read_enable_i     = 1'b0;
        mem_write_enable_i    = 4'h0;
        killed_i              = 1'b0;
        rnd                   = 32'd74419;
        exp_exc               = 6'd0;
        errors                = 0;
        test_errors           = 0;
        tests_run             = 0;
        tests_failed          = 0;
        shadow_reset();
        wait_reset(reset_ok);
        if (!reset_ok) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Simulation finished: FAIL");
            $finish;
        end
        else begin
            begin_test("reset_values");
            for (int i = 0; i < 7; i++)
                csr_read(A_CTL + 12'(i));
            end_test();

            begin_test("csr_round_trip");
            for (int n = 0; n < 40; n++) begin
                next_rand();
                rt_addr = A_CTL + 12'(rnd % 32'd7);
                next_rand();
                csr_write(rt_addr, rnd);
                csr_read(rt_addr);
            end
            end_test();

            begin_test("translation_off");
            // Machine mode ignores an enabled window
            set_priv(core_pkg::PRIV_MACHINE);
            csr_write(A_CTL, 32'h1);
            random_window();
            for (int n = 0; n < 20; n++)
                traffic_cycle(1'b0);
            // Any privilege with the control bit clear
            csr_write(A_CTL, 32'h0);
            for (int n = 0; n < 20; n++)
                traffic_cycle(1'b1);
            end_test();

            begin_test("translation_on");
            set_priv(core_pkg::PRIV_USER);
            csr_write(A_CTL, 32'h1);
            for (int w = 0; w < 6; w++) begin
                random_window();
                for (int n = 0; n < 10; n++)
                    traffic_cycle(1'b0);
            end
            end_test();

            begin_test("gating_and_causes");
            for (int w = 0; w < 6; w++) begin
                random_window();
                for (int n = 0; n < 15; n++)
                    traffic_cycle(1'b1);
            end
            // Last report still in flight
            next_edge();
            end_test();

            $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
            if (errors == 0) begin
                $display("Simulation finished: PASS");
            end
            else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
core_pkg.sv
mvm_pkg.sv
mvm_csr_bank.sv
mmu_window.sv
access_guard.sv
xosvm_unit.sv
tb_xosvm_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, the log decides pass or fail
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_xosvm_unit -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
    echo "Run passed"
else
    echo "Run failed"
    exit 1
fi
